// ==== design/attn_types_pkg.sv ====
/* Widths are sized for 8x8 matrices of signed 8-bit inputs.
   out_t wraps if the score by V sum exceeds 60 bits. */
`default_nettype none

package attn_types_pkg;

    // Matrix dimension for tokens, weights and projections
    localparam int dim = 8;

    typedef logic [2:0] idx_t;

    // ##############################
    // Element types per stage
    // ##############################
    typedef logic signed [7:0]  token_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [18:0] proj_t;
    typedef logic signed [40:0] score_t;
    typedef logic signed [59:0] out_t;

    // Names W_Q/Q, W_K/K or W_V/V
    typedef enum logic [1:0] {
        mat_q = 2'd0,
        mat_k = 2'd1,
        mat_v = 2'd2
    } mat_sel_t;

endpackage

`default_nettype wire

// ==== design/attn_ctrl_pkg.sv ====
/* Phase lengths assume one session of 192 input cycles. */
`default_nettype none

package attn_ctrl_pkg;

    typedef enum logic [2:0] {
        idle    = 3'd0,
        load    = 3'd1,
        project = 3'd2,
        score   = 3'd3,
        emit    = 3'd4
    } state_t;

    typedef logic [3:0] seq_len_t;
    typedef logic [7:0] phase_cnt_t;

    // Cycles per phase, emit excluded since it follows the length
    localparam int load_cycles    = 192;
    localparam int project_cycles = 24;
    localparam int score_cycles   = 64;

    // Accepted token counts
    localparam seq_len_t len_one   = 4'd1;
    localparam seq_len_t len_four  = 4'd4;
    localparam seq_len_t len_eight = 4'd8;

endpackage

`default_nettype wire

// ==== design/dot8.sv ====
/* Combinational only. The sum wraps if sum_t is too narrow for the products. */
`timescale 1ns/1ps
`default_nettype none

module dot8 #(
    parameter type a_t   = logic signed [7:0],
    parameter type b_t   = logic signed [7:0],
    parameter type sum_t = logic signed [18:0]
) (
    input  a_t   a [8],
    input  b_t   b [8],
    output sum_t sum
);

    // Operands are widened to the sum type before the multiply
    always_comb begin
        sum = '0;
        for (int i = 0; i < 8; i++) begin
            sum = sum + sum_t'(a[i]) * sum_t'(b[i]);
        end
    end

endmodule

`default_nettype wire

// ==== design/attn_ctrl.sv ====
/* in_valid is only looked at in idle. load_en and load_idx are combinational
   so the first input cycle is written. The other indices are registered. */
`timescale 1ns/1ps
`default_nettype none

module attn_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  attn_ctrl_pkg::seq_len_t    seq_len,
    output logic                       load_en,
    output attn_ctrl_pkg::phase_cnt_t  load_idx,
    output attn_ctrl_pkg::seq_len_t    token_len,
    output logic                       proj_en,
    output attn_types_pkg::mat_sel_t   proj_mat,
    output attn_types_pkg::idx_t       proj_col,
    output logic                       score_en,
    output attn_types_pkg::idx_t       score_row,
    output attn_types_pkg::idx_t       score_col,
    output logic                       emit_en,
    output attn_types_pkg::idx_t       emit_row,
    output attn_types_pkg::idx_t       emit_col
);

    attn_ctrl_pkg::state_t     state;
    attn_ctrl_pkg::state_t     state_next;
    attn_ctrl_pkg::phase_cnt_t cnt;
    attn_ctrl_pkg::phase_cnt_t cnt_last;
    attn_ctrl_pkg::seq_len_t   len_q;
    logic                      len_ok;
    logic                      start;

    assign len_ok = (seq_len == attn_ctrl_pkg::len_one)  ||
                    (seq_len == attn_ctrl_pkg::len_four) ||
                    (seq_len == attn_ctrl_pkg::len_eight);
    assign start  = (state == attn_ctrl_pkg::idle) && in_valid && len_ok;

    // The start cycle is load index 0
    assign load_en   = start || (state == attn_ctrl_pkg::load);
    assign load_idx  = (state == attn_ctrl_pkg::load) ? cnt : '0;
    assign token_len = (state == attn_ctrl_pkg::idle) ? seq_len : len_q;

    // ##############################
    // Phase sequencing
    // ##############################
    always_comb begin
        cnt_last   = '0;
        state_next = attn_ctrl_pkg::idle;
        case (state)
            attn_ctrl_pkg::load: begin
                cnt_last   = attn_ctrl_pkg::phase_cnt_t'(attn_ctrl_pkg::load_cycles - 1);
                state_next = attn_ctrl_pkg::project;
            end
            attn_ctrl_pkg::project: begin
                cnt_last   = attn_ctrl_pkg::phase_cnt_t'(attn_ctrl_pkg::project_cycles - 1);
                state_next = attn_ctrl_pkg::score;
            end
            attn_ctrl_pkg::score: begin
                cnt_last   = attn_ctrl_pkg::phase_cnt_t'(attn_ctrl_pkg::score_cycles - 1);
                state_next = attn_ctrl_pkg::emit;
            end
            attn_ctrl_pkg::emit: begin
                // Eight outputs per token
                cnt_last   = attn_ctrl_pkg::phase_cnt_t'({len_q, 3'b000}) - 8'd1;
                state_next = attn_ctrl_pkg::idle;
            end
            default: begin
                cnt_last   = '0;
                state_next = attn_ctrl_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= attn_ctrl_pkg::idle;
            cnt   <= '0;
            len_q <= '0;
        end else if (state == attn_ctrl_pkg::idle) begin
            if (start) begin
                state <= attn_ctrl_pkg::load;
                cnt   <= 8'd1;
                len_q <= seq_len;
            end
        end else if (cnt == cnt_last) begin
            state <= state_next;
            cnt   <= '0;
        end else begin
            cnt <= cnt + 8'd1;
        end
    end

    // ##############################
    // Registered phase indices
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            proj_en   <= 1'b0;
            proj_mat  <= attn_types_pkg::mat_q;
            proj_col  <= '0;
            score_en  <= 1'b0;
            score_row <= '0;
            score_col <= '0;
            emit_en   <= 1'b0;
            emit_row  <= '0;
            emit_col  <= '0;
        end else begin
            proj_en  <= (state == attn_ctrl_pkg::project);
            score_en <= (state == attn_ctrl_pkg::score);
            emit_en  <= (state == attn_ctrl_pkg::emit);
            if (state == attn_ctrl_pkg::project) begin
                // Eight columns of Q, then K, then V
                proj_mat <= attn_types_pkg::mat_sel_t'(cnt[4:3]);
                proj_col <= cnt[2:0];
            end
            if (state == attn_ctrl_pkg::score) begin
                score_row <= cnt[5:3];
                score_col <= cnt[2:0];
            end
            if (state == attn_ctrl_pkg::emit) begin
                emit_row <= cnt[5:3];
                emit_col <= cnt[2:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/input_buffer.sv ====
/* Token rows at or beyond token_len stay zero. proj_mat must name one of
   the three stored matrices when weight_col is used. */
`timescale 1ns/1ps
`default_nettype none

module input_buffer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_en,
    input  attn_ctrl_pkg::phase_cnt_t load_idx,
    input  attn_ctrl_pkg::seq_len_t   token_len,
    input  attn_types_pkg::token_t    token_data,
    input  attn_types_pkg::weight_t   weight_data,
    input  attn_types_pkg::mat_sel_t  proj_mat,
    input  attn_types_pkg::idx_t      proj_col,
    output attn_types_pkg::token_t    token_mat [attn_types_pkg::dim][attn_types_pkg::dim],
    output attn_types_pkg::weight_t   weight_col [attn_types_pkg::dim]
);

    // Indexed [matrix][input dim][output dim]
    attn_types_pkg::weight_t weight_mem [3][attn_types_pkg::dim][attn_types_pkg::dim];

    logic token_wr;

    assign token_wr = load_en &&
                      (load_idx < attn_ctrl_pkg::phase_cnt_t'({token_len, 3'b000}));

    // ##############################
    // Token matrix
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < attn_types_pkg::dim; r++) begin
                for (int c = 0; c < attn_types_pkg::dim; c++) begin
                    token_mat[r][c] <= '0;
                end
            end
        end else begin
            // New session clears rows left over from a longer one
            if (load_en && (load_idx == '0)) begin
                for (int r = 0; r < attn_types_pkg::dim; r++) begin
                    for (int c = 0; c < attn_types_pkg::dim; c++) begin
                        token_mat[r][c] <= '0;
                    end
                end
            end
            if (token_wr) begin
                token_mat[load_idx[5:3]][load_idx[2:0]] <= token_data;
            end
        end
    end

    // Weight phase is load_idx[7:6]
    always_ff @(posedge clk) begin
        if (load_en) begin
            weight_mem[load_idx[7:6]][load_idx[5:3]][load_idx[2:0]] <= weight_data;
        end
    end

    always_comb begin
        for (int j = 0; j < attn_types_pkg::dim; j++) begin
            weight_col[j] = weight_mem[proj_mat][j][proj_col];
        end
    end

endmodule

`default_nettype wire

// ==== design/qkv_projector.sv ====
/* One column of the selected matrix per proj_en cycle. Results show one
   cycle after proj_en. */
`timescale 1ns/1ps
`default_nettype none

module qkv_projector (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     proj_en,
    input  attn_types_pkg::mat_sel_t proj_mat,
    input  attn_types_pkg::idx_t     proj_col,
    input  attn_types_pkg::token_t   token_mat [attn_types_pkg::dim][attn_types_pkg::dim],
    input  attn_types_pkg::weight_t  weight_col [attn_types_pkg::dim],
    input  attn_types_pkg::idx_t     score_row,
    input  attn_types_pkg::idx_t     score_col,
    output attn_types_pkg::proj_t    q_row [attn_types_pkg::dim],
    output attn_types_pkg::proj_t    k_row [attn_types_pkg::dim],
    output attn_types_pkg::proj_t    v_mat [attn_types_pkg::dim][attn_types_pkg::dim]
);

    attn_types_pkg::proj_t q_mat   [attn_types_pkg::dim][attn_types_pkg::dim];
    attn_types_pkg::proj_t k_mat   [attn_types_pkg::dim][attn_types_pkg::dim];
    attn_types_pkg::proj_t col_sum [attn_types_pkg::dim];

    // One dot product per token row against the weight column
    for (genvar r = 0; r < attn_types_pkg::dim; r++) begin : g_row
        dot8 #(
            .a_t   (attn_types_pkg::token_t),
            .b_t   (attn_types_pkg::weight_t),
            .sum_t (attn_types_pkg::proj_t)
        ) u_dot8 (
            .a   (token_mat[r]),
            .b   (weight_col),
            .sum (col_sum[r])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < attn_types_pkg::dim; r++) begin
                for (int c = 0; c < attn_types_pkg::dim; c++) begin
                    q_mat[r][c] <= '0;
                    k_mat[r][c] <= '0;
                    v_mat[r][c] <= '0;
                end
            end
        end else if (proj_en) begin
            for (int r = 0; r < attn_types_pkg::dim; r++) begin
                case (proj_mat)
                    attn_types_pkg::mat_q: q_mat[r][proj_col] <= col_sum[r];
                    attn_types_pkg::mat_k: k_mat[r][proj_col] <= col_sum[r];
                    attn_types_pkg::mat_v: v_mat[r][proj_col] <= col_sum[r];
                    default: ;
                endcase
            end
        end
    end

    // Score entry [r][c] needs Q row r and K row c
    assign q_row = q_mat[score_row];
    assign k_row = k_mat[score_col];

endmodule

`default_nettype wire

// ==== design/score_unit.sv ====
/* Scores are max(q.k, 0) / 3, truncated. Entries show one cycle after
   score_en. */
`timescale 1ns/1ps
`default_nettype none

module score_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   score_en,
    input  attn_types_pkg::idx_t   score_row,
    input  attn_types_pkg::idx_t   score_col,
    input  attn_types_pkg::proj_t  q_row [attn_types_pkg::dim],
    input  attn_types_pkg::proj_t  k_row [attn_types_pkg::dim],
    input  attn_types_pkg::idx_t   emit_row,
    output attn_types_pkg::score_t score_row_data [attn_types_pkg::dim]
);

    attn_types_pkg::score_t score_mat [attn_types_pkg::dim][attn_types_pkg::dim];
    attn_types_pkg::score_t qk_dot;

    dot8 #(
        .a_t   (attn_types_pkg::proj_t),
        .b_t   (attn_types_pkg::proj_t),
        .sum_t (attn_types_pkg::score_t)
    ) u_dot8 (
        .a   (q_row),
        .b   (k_row),
        .sum (qk_dot)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < attn_types_pkg::dim; r++) begin
                for (int c = 0; c < attn_types_pkg::dim; c++) begin
                    score_mat[r][c] <= '0;
                end
            end
        end else if (score_en) begin
            // Clamp negatives, divide the rest
            if (qk_dot > 0) begin
                score_mat[score_row][score_col] <= qk_dot / 3;
            end else begin
                score_mat[score_row][score_col] <= '0;
            end
        end
    end

    assign score_row_data = score_mat[emit_row];

endmodule

`default_nettype wire

// ==== design/output_unit.sv ====
/* No back-pressure. out_data is zero whenever out_valid is low. */
`timescale 1ns/1ps
`default_nettype none

module output_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   emit_en,
    input  attn_types_pkg::idx_t   emit_col,
    input  attn_types_pkg::score_t score_row_data [attn_types_pkg::dim],
    input  attn_types_pkg::proj_t  v_mat [attn_types_pkg::dim][attn_types_pkg::dim],
    output logic                   out_valid,
    output attn_types_pkg::out_t   out_data
);

    attn_types_pkg::proj_t v_col [attn_types_pkg::dim];
    attn_types_pkg::out_t  sv_dot;

    // Column emit_col of V
    always_comb begin
        for (int k = 0; k < attn_types_pkg::dim; k++) begin
            v_col[k] = v_mat[k][emit_col];
        end
    end

    dot8 #(
        .a_t   (attn_types_pkg::score_t),
        .b_t   (attn_types_pkg::proj_t),
        .sum_t (attn_types_pkg::out_t)
    ) u_dot8 (
        .a   (score_row_data),
        .b   (v_col),
        .sum (sv_dot)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= emit_en;
            out_data  <= emit_en ? sv_dot : '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/attn_top.sv ====
/* seq_len is sampled on the first in_valid cycle only. The consumer must
   take every out_valid cycle. */
`timescale 1ns/1ps
`default_nettype none

module attn_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  attn_ctrl_pkg::seq_len_t seq_len,
    input  attn_types_pkg::token_t  token_data,
    input  attn_types_pkg::weight_t weight_data,
    output logic                    out_valid,
    output attn_types_pkg::out_t    out_data
);

    // ##############################
    // Control wires
    // ##############################
    logic                      load_en;
    attn_ctrl_pkg::phase_cnt_t load_idx;
    attn_ctrl_pkg::seq_len_t   token_len;
    logic                      proj_en;
    attn_types_pkg::mat_sel_t  proj_mat;
    attn_types_pkg::idx_t      proj_col;
    logic                      score_en;
    attn_types_pkg::idx_t      score_row;
    attn_types_pkg::idx_t      score_col;
    logic                      emit_en;
    attn_types_pkg::idx_t      emit_row;
    attn_types_pkg::idx_t      emit_col;

    // Datapath wires
    attn_types_pkg::token_t  token_mat [attn_types_pkg::dim][attn_types_pkg::dim];
    attn_types_pkg::weight_t weight_col [attn_types_pkg::dim];
    attn_types_pkg::proj_t   q_row [attn_types_pkg::dim];
    attn_types_pkg::proj_t   k_row [attn_types_pkg::dim];
    attn_types_pkg::proj_t   v_mat [attn_types_pkg::dim][attn_types_pkg::dim];
    attn_types_pkg::score_t  score_row_data [attn_types_pkg::dim];

    attn_ctrl u_attn_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .seq_len   (seq_len),
        .load_en   (load_en),
        .load_idx  (load_idx),
        .token_len (token_len),
        .proj_en   (proj_en),
        .proj_mat  (proj_mat),
        .proj_col  (proj_col),
        .score_en  (score_en),
        .score_row (score_row),
        .score_col (score_col),
        .emit_en   (emit_en),
        .emit_row  (emit_row),
        .emit_col  (emit_col)
    );

    input_buffer u_input_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en     (load_en),
        .load_idx    (load_idx),
        .token_len   (token_len),
        .token_data  (token_data),
        .weight_data (weight_data),
        .proj_mat    (proj_mat),
        .proj_col    (proj_col),
        .token_mat   (token_mat),
        .weight_col  (weight_col)
    );

    qkv_projector u_qkv_projector (
        .clk        (clk),
        .rst_n      (rst_n),
        .proj_en    (proj_en),
        .proj_mat   (proj_mat),
        .proj_col   (proj_col),
        .token_mat  (token_mat),
        .weight_col (weight_col),
        .score_row  (score_row),
        .score_col  (score_col),
        .q_row      (q_row),
        .k_row      (k_row),
        .v_mat      (v_mat)
    );

    score_unit u_score_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .score_en       (score_en),
        .score_row      (score_row),
        .score_col      (score_col),
        .q_row          (q_row),
        .k_row          (k_row),
        .emit_row       (emit_row),
        .score_row_data (score_row_data)
    );

    output_unit u_output_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .emit_en        (emit_en),
        .emit_col       (emit_col),
        .score_row_data (score_row_data),
        .v_mat          (v_mat),
        .out_valid      (out_valid),
        .out_data       (out_data)
    );

endmodule

`default_nettype wire

// ==== verification/attn_tb.sv ====
/* Self-checking testbench for attn_top. Operands stay in -4..3, so every
   intermediate value fits the DUT widths and the model needs no wrapping. */
`timescale 1ns/1ps
`default_nettype none

module attn_tb;

    localparam int cycle_timeout = 500;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    attn_ctrl_pkg::seq_len_t seq_len;
    attn_types_pkg::token_t  token_data;
    attn_types_pkg::weight_t weight_data;
    logic                    out_valid;
    attn_types_pkg::out_t    out_data;

    logic [31:0] rng_state;
    logic        expecting;
    int          value_errors;
    int          other_errors;
    int          neg_scores;
    int          frac_scores;

    // Operands of the current session and its expected outputs
    int     tok_m [8][8];
    int     w_m [3][8][8];
    longint exp_out [64];

    attn_top u_attn_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .seq_len     (seq_len),
        .token_data  (token_data),
        .weight_data (weight_data),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ##############################
    // Output properties
    // ##############################
    data_zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_data == '0)
        else begin
            value_errors++;
            $display("CHECK FAILED at %0t: out_data expected 0, got %0d",
                     $time, $sampled(out_data));
        end

    // Output only inside a collection window
    valid_only_when_expected: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> expecting)
        else begin
            other_errors++;
            $display("out_valid went high at %0t while no output was due", $time);
        end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Signed value in -4..3 from upper LCG bits
    function automatic int next_small();
        logic signed [2:0] v;
        rng_state = lcg_next(rng_state);
        v = rng_state[18:16];
        return int'(v);
    endfunction

    task automatic fill_operands(input bit negate_k);
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                tok_m[r][c] = next_small();
                for (int m = 0; m < 3; m++) begin
                    w_m[m][r][c] = next_small();
                end
                // K = -Q makes every diagonal score negative
                if (negate_k) begin
                    w_m[1][r][c] = -w_m[0][r][c];
                end
            end
        end
    endtask

    // ##############################
    // Reference model
    // ##############################
    task automatic compute_expected(input int len);
        longint q [8][8];
        longint k [8][8];
        longint v [8][8];
        longint s [8][8];
        longint acc;
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                q[r][c] = 0;
                k[r][c] = 0;
                v[r][c] = 0;
                // Rows past the length count as zero tokens
                if (r < len) begin
                    for (int j = 0; j < 8; j++) begin
                        q[r][c] += tok_m[r][j] * w_m[0][j][c];
                        k[r][c] += tok_m[r][j] * w_m[1][j][c];
                        v[r][c] += tok_m[r][j] * w_m[2][j][c];
                    end
                end
            end
        end
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                acc = 0;
                for (int j = 0; j < 8; j++) begin
                    acc += q[r][j] * k[c][j];
                end
                if (acc < 0) begin
                    neg_scores++;
                end else if (acc % 3 != 0) begin
                    frac_scores++;
                end
                s[r][c] = (acc > 0) ? acc / 3 : 0;
            end
        end
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                acc = 0;
                for (int j = 0; j < 8; j++) begin
                    acc += s[r][j] * v[j][c];
                end
                exp_out[r * 8 + c] = acc;
            end
        end
    endtask

    // 192 input cycles, seq_len switches to later_len after the first one
    task automatic run_session(input int first_len, input int later_len);
        for (int cyc = 0; cyc < attn_ctrl_pkg::load_cycles; cyc++) begin
            @(negedge clk);
            in_valid = 1'b1;
            seq_len  = attn_ctrl_pkg::seq_len_t'((cyc == 0) ? first_len : later_len);
            if (cyc < first_len * 8) begin
                token_data = attn_types_pkg::token_t'(tok_m[cyc / 8][cyc % 8]);
            end else begin
                token_data = attn_types_pkg::token_t'(next_small() + 5);
            end
            weight_data = attn_types_pkg::weight_t'(w_m[cyc / 64][(cyc % 64) / 8][cyc % 8]);
        end
        @(negedge clk);
        in_valid    = 1'b0;
        seq_len     = '0;
        token_data  = '0;
        weight_data = '0;
    endtask

    task automatic collect_outputs(input int len);
        int     wait_cnt;
        int     n;
        longint got;
        wait_cnt  = 0;
        n         = 0;
        expecting = 1'b1;
        while (!out_valid && wait_cnt < cycle_timeout) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!out_valid) begin
            other_errors++;
            $display("Timed out after %0d cycles waiting for out_valid", cycle_timeout);
        end
        // Bounded by one more than the longest session
        while (out_valid && n <= 64) begin
            got = out_data;
            if (n < len * 8) begin
                out_value: assert (got == exp_out[n])
                    else begin
                        value_errors++;
                        $display("CHECK FAILED at %0t: out_data[%0d] expected %0d, got %0d",
                                 $time, n, exp_out[n], got);
                    end
            end
            n++;
            @(negedge clk);
        end
        out_count: assert (n == len * 8)
            else begin
                value_errors++;
                $display("CHECK FAILED at %0t: out_valid cycles expected %0d, got %0d",
                         $time, len * 8, n);
            end
        expecting = 1'b0;
    endtask

    task automatic idle_cycles(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic full_session(input int first_len, input int later_len, input bit negate_k);
        fill_operands(negate_k);
        compute_expected(first_len);
        run_session(first_len, later_len);
        collect_outputs(first_len);
        idle_cycles(2);
    endtask

    // ##############################
    // Test sequence
    // ##############################
    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        seq_len      = '0;
        token_data   = '0;
        weight_data  = '0;
        expecting    = 1'b0;
        rng_state    = 32'h9bb9_da03;
        value_errors = 0;
        other_errors = 0;
        neg_scores   = 0;
        frac_scores  = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Quiet outputs before any session
        idle_cycles(20);

        full_session(8, 8, 1'b0);
        full_session(4, 4, 1'b0);
        full_session(1, 1, 1'b0);
        full_session(8, 8, 1'b1);

        // Length 5 must not start a session
        fill_operands(1'b0);
        run_session(5, 5);
        idle_cycles(cycle_timeout);
        full_session(4, 4, 1'b0);

        // Only the first cycle's length counts
        full_session(4, 8, 1'b0);
        full_session(8, 1, 1'b0);

        stim_reach: assert (neg_scores > 0 && frac_scores > 0)
            else begin
                other_errors++;
                $display("Stimulus gave no negative score or no score off a multiple of 3");
            end

        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== attn_engine.f ====
design/attn_types_pkg.sv
design/attn_ctrl_pkg.sv
design/dot8.sv
design/attn_ctrl.sv
design/input_buffer.sv
design/qkv_projector.sv
design/score_unit.sv
design/output_unit.sv
design/attn_top.sv
verification/attn_tb.sv

// ==== Bender.yml ====
package:
  name: attn_engine

sources:
  - design/attn_types_pkg.sv
  - design/attn_ctrl_pkg.sv
  - design/dot8.sv
  - design/attn_ctrl.sv
  - design/input_buffer.sv
  - design/qkv_projector.sv
  - design/score_unit.sv
  - design/output_unit.sv
  - design/attn_top.sv
  - target: simulation
    files:
      - verification/attn_tb.sv
